// ==== dv/fetch_assert.sv ====
/*
 * Output invariants of the pc stage, bound into pc_gen_stage by the
 * testbench top.
 */
`timescale 1ns/1ns
`default_nettype none

module fetch_assert (
    input logic clk_i,
    input logic rstn_i,
    input logic retry_fetch_i,
    input logic icache_req_valid_i,
    input logic icache_inval_buffer_i,
    input logic fetch_valid_i,
    input logic fetch_xcpt_valid_i,
    input logic bpred_is_branch_i,
    input logic bpred_taken_i
);

    // no cache request for an instruction that is not fetched
    req_implies_fetch: assert property (@(posedge clk_i) disable iff (!rstn_i)
        icache_req_valid_i |-> fetch_valid_i)
        else $error("icache request valid without fetch valid");

    xcpt_blocks_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
        fetch_xcpt_valid_i |-> !icache_req_valid_i)
        else $error("icache request valid while an exception is reported");

    taken_needs_hit: assert property (@(posedge clk_i) disable iff (!rstn_i)
        bpred_taken_i |-> bpred_is_branch_i)
        else $error("taken prediction without a btb hit");

    // retry always flushes the fetch buffer
    retry_flushes_buffer: assert property (@(posedge clk_i) disable iff (!rstn_i)
        retry_fetch_i |-> icache_inval_buffer_i)
        else $error("retry without buffer invalidate");

endmodule

`default_nettype wire

// ==== dv/fetch_checker.sv ====
/*
 * Reference model of the fetch unit for the testbench.
 * Tracks the pc and the target buffer and compares every DUT output
 * at each rising edge, before the model steps.
 */
`timescale 1ns/1ns
`default_nettype none

module fetch_checker #(
    parameter int unsigned BTB_ENTRIES = 16
) (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  fetch_pkg::addr_pc_t     reset_addr_i,
    input  fetch_pkg::next_pc_sel_e next_pc_sel_i,
    input  fetch_pkg::addr_pc_t     jump_pc_i,
    input  logic                    stall_i,
    input  logic                    stall_debug_i,
    input  logic                    en_translation_i,
    input  logic                    invalidate_icache_i,
    input  logic                    invalidate_buffer_i,
    input  logic                    retry_fetch_i,
    input  logic                    exe_is_branch_i,
    input  fetch_pkg::addr_pc_t     exe_pc_i,
    input  logic                    exe_taken_i,
    input  fetch_pkg::addr_pc_t     exe_target_i,

    // observed DUT outputs
    input  logic                    req_valid_i,
    input  fetch_pkg::vaddr_t       req_vaddr_i,
    input  logic                    inval_i,
    input  logic                    inval_buffer_i,
    input  logic                    inval_fetch_i,
    input  logic                    fetch_valid_i,
    input  fetch_pkg::addr_pc_t     fetch_pc_i,
    input  logic                    xcpt_valid_i,
    input  fetch_pkg::xcpt_cause_t  xcpt_cause_i,
    input  logic                    bp_is_branch_i,
    input  logic                    bp_taken_i,
    input  fetch_pkg::addr_pc_t     bp_addr_i,

    output int                      error_count_o,
    output int                      check_count_o
);
    import fetch_pkg::*;

    localparam int unsigned IDX_W = $clog2(BTB_ENTRIES);

    // model state, tags kept as the shifted pc
    addr_pc_t               pc_m;
    logic [BTB_ENTRIES-1:0] valid_m;
    addr_pc_t               tag_m    [BTB_ENTRIES];
    addr_pc_t               target_m [BTB_ENTRIES];
    logic [1:0]             cnt_m    [BTB_ENTRIES];

    int errors;
    int checks;

    assign error_count_o = errors;
    assign check_count_o = checks;

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %b, actual %b at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_word(input string name, input addr_pc_t exp, input addr_pc_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, actual %h at %0t", name, exp, act, $time);
        end
    endtask

    always @(posedge clk_i) begin : model_step
        logic [IDX_W-1:0] f_idx;
        logic [IDX_W-1:0] e_idx;
        logic             hit;
        logic             taken;
        logic             misaligned;
        logic             fault;
        logic [1:0]       cnt;
        xcpt_cause_t      exp_cause;
        if (!rstn_i) begin
            pc_m    <= reset_addr_i;
            valid_m <= '0;
            errors  = 0;
            checks  = 0;
        end else begin
            f_idx = IDX_W'(pc_m >> 2);
            hit   = valid_m[f_idx] && (tag_m[f_idx] == (pc_m >> (IDX_W + 2)));
            taken = hit && cnt_m[f_idx][1];

            misaligned = pc_m[1:0] != 2'b00;
            if (en_translation_i) begin
                // canonical means sign extension of the 39-bit address
                fault = {{(64 - VIRT_ADDR_SIZE){pc_m[VIRT_ADDR_SIZE - 1]}},
                         pc_m[VIRT_ADDR_SIZE - 1:0]} != pc_m;
            end else begin
                fault = !(((pc_m - ROM_BASE) < ROM_SIZE) || ((pc_m - DRAM_BASE) < DRAM_SIZE));
            end
            exp_cause = CAUSE_INSTR_MISALIGNED;
            if (!misaligned && fault) begin
                exp_cause = CAUSE_INSTR_ACCESS_FAULT;
            end

            check_word("fetch_pc", pc_m, fetch_pc_i);
            check_bit("fetch_valid", !(stall_i || stall_debug_i), fetch_valid_i);
            check_bit("req_valid", !(stall_i || stall_debug_i || misaligned || fault),
                      req_valid_i);
            check_word("req_vaddr", 64'(pc_m[39:0]), 64'(req_vaddr_i));
            check_bit("inval", invalidate_icache_i, inval_i);
            check_bit("inval_buffer", invalidate_buffer_i || retry_fetch_i, inval_buffer_i);
            check_bit("inval_fetch", retry_fetch_i, inval_fetch_i);
            check_bit("xcpt_valid", misaligned || fault, xcpt_valid_i);
            check_word("xcpt_cause", exp_cause, xcpt_cause_i);
            check_bit("bpred_is_branch", hit, bp_is_branch_i);
            check_bit("bpred_taken", taken, bp_taken_i);
            if (hit) begin
                check_word("bpred_addr", target_m[f_idx], bp_addr_i);
            end

            case (next_pc_sel_i)
                NEXT_PC_KEEP: pc_m <= pc_m;
                NEXT_PC_BP_OR_PC4: pc_m <= taken ? target_m[f_idx] : pc_m + 64'd4;
                default: pc_m <= jump_pc_i;
            endcase

            if (exe_is_branch_i) begin
                e_idx = IDX_W'(exe_pc_i >> 2);
                if (valid_m[e_idx] && (tag_m[e_idx] == (exe_pc_i >> (IDX_W + 2)))) begin
                    cnt = cnt_m[e_idx];
                    if (exe_taken_i) begin
                        cnt = (cnt == 2'd3) ? 2'd3 : cnt + 2'd1;
                        target_m[e_idx] <= exe_target_i;
                    end else begin
                        cnt = (cnt == 2'd0) ? 2'd0 : cnt - 2'd1;
                    end
                end else begin
                    // new or conflicting branch takes the entry over
                    cnt = exe_taken_i ? 2'd2 : 2'd1;
                    valid_m[e_idx]  <= 1'b1;
                    tag_m[e_idx]    <= exe_pc_i >> (IDX_W + 2);
                    target_m[e_idx] <= exe_target_i;
                end
                cnt_m[e_idx] <= cnt;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_fetch_unit.sv ====
/*
 * Testbench top for the fetch unit. Drives LFSR random control, jump and
 * training traffic on the falling edge; fetch_checker does the comparing.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_unit;
    import fetch_pkg::*;

    localparam int unsigned BTB_ENTRIES    = 16;
    localparam int          RUN_CYCLES     = 3000;
    localparam int          WARMUP_CYCLES  = 8;
    // reset plus run, with a third of margin
    localparam int          TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 3;

    logic         clk_i;
    logic         rstn_i;
    addr_pc_t     reset_addr_i;
    next_pc_sel_e next_pc_sel_i;
    addr_pc_t     jump_pc_i;
    logic         stall_i;
    logic         stall_debug_i;
    logic         en_translation_i;
    logic         invalidate_icache_i;
    logic         invalidate_buffer_i;
    logic         retry_fetch_i;
    logic         exe_is_branch_i;
    addr_pc_t     exe_pc_i;
    logic         exe_taken_i;
    addr_pc_t     exe_target_i;
    logic         icache_req_valid_o;
    vaddr_t       icache_req_vaddr_o;
    logic         icache_inval_o;
    logic         icache_inval_buffer_o;
    logic         icache_inval_fetch_o;
    logic         fetch_valid_o;
    addr_pc_t     fetch_pc_o;
    logic         fetch_xcpt_valid_o;
    xcpt_cause_t  fetch_xcpt_cause_o;
    logic         bpred_is_branch_o;
    logic         bpred_taken_o;
    addr_pc_t     bpred_addr_o;

    int           error_count;
    int           check_count;
    int           cycle_count;
    logic [31:0]  lfsr;

    fetch_unit #(.BTB_ENTRIES(BTB_ENTRIES)) dut0 (.*);

    fetch_checker #(.BTB_ENTRIES(BTB_ENTRIES)) chk0 (
        .*,
        .req_valid_i    (icache_req_valid_o),
        .req_vaddr_i    (icache_req_vaddr_o),
        .inval_i        (icache_inval_o),
        .inval_buffer_i (icache_inval_buffer_o),
        .inval_fetch_i  (icache_inval_fetch_o),
        .fetch_valid_i  (fetch_valid_o),
        .fetch_pc_i     (fetch_pc_o),
        .xcpt_valid_i   (fetch_xcpt_valid_o),
        .xcpt_cause_i   (fetch_xcpt_cause_o),
        .bp_is_branch_i (bpred_is_branch_o),
        .bp_taken_i     (bpred_taken_o),
        .bp_addr_i      (bpred_addr_o),
        .error_count_o  (error_count),
        .check_count_o  (check_count)
    );

    bind pc_gen_stage fetch_assert assert0 (
        .clk_i                 (clk_i),
        .rstn_i                (rstn_i),
        .retry_fetch_i         (retry_fetch_i),
        .icache_req_valid_i    (icache_req_valid_o),
        .icache_inval_buffer_i (icache_inval_buffer_o),
        .fetch_valid_i         (fetch_valid_o),
        .fetch_xcpt_valid_i    (fetch_xcpt_valid_o),
        .bpred_is_branch_i     (bpred_is_branch_o),
        .bpred_taken_i         (bpred_taken_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #4 clk_i = ~clk_i;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [63:0] draw_bits(input int n);
        logic [63:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            val  = {val[62:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic addr_pc_t pick_jump_target();
        addr_pc_t target;
        int       kind;
        kind = int'(draw_bits(3));
        case (kind)
            0, 1: target = ROM_BASE + (draw_bits(14) << 2);
            2, 3: target = DRAM_BASE + (draw_bits(26) << 2);
            4: target = 64'hFFFF_FFC0_0000_0000 | (draw_bits(36) << 2);
            5: target = draw_bits(64) & ~64'h3;
            6: target = draw_bits(6) << 2;
            // misaligned, on a mapped or an unmapped base
            default: target = ((draw_bits(1) != 64'd0) ? ROM_BASE : 64'h4000_0000)
                              + (draw_bits(14) << 2) + 64'd1 + draw_bits(1);
        endcase
        return target;
    endfunction

    task automatic drive_idle();
        next_pc_sel_i       = NEXT_PC_BP_OR_PC4;
        jump_pc_i           = '0;
        stall_i             = 1'b0;
        stall_debug_i       = 1'b0;
        en_translation_i    = 1'b0;
        invalidate_icache_i = 1'b0;
        invalidate_buffer_i = 1'b0;
        retry_fetch_i       = 1'b0;
        exe_is_branch_i     = 1'b0;
        exe_pc_i            = '0;
        exe_taken_i         = 1'b0;
        exe_target_i        = '0;
    endtask

    task automatic drive_random();
        int roll;
        roll = int'(draw_bits(4));
        if (roll < 10) begin
            next_pc_sel_i = NEXT_PC_BP_OR_PC4;
        end else if (roll < 12) begin
            next_pc_sel_i = NEXT_PC_KEEP;
        end else if (roll < 15) begin
            next_pc_sel_i = NEXT_PC_JUMP;
        end else begin
            next_pc_sel_i = NEXT_PC_DEBUG;
        end
        jump_pc_i           = pick_jump_target();
        stall_i             = draw_bits(3) == 64'd0;
        stall_debug_i       = draw_bits(4) == 64'd0;
        en_translation_i    = draw_bits(2) == 64'd0;
        invalidate_icache_i = draw_bits(3) == 64'd0;
        invalidate_buffer_i = draw_bits(3) == 64'd0;
        retry_fetch_i       = draw_bits(3) == 64'd0;
        // train close to the current pc, sometimes on a conflicting tag
        exe_is_branch_i = draw_bits(2) == 64'd0;
        exe_pc_i        = (fetch_pc_o & ~64'h3) + (draw_bits(2) << 2)
                          + ((draw_bits(2) == 64'd0) ? 64'(BTB_ENTRIES * 4) : 64'd0);
        exe_taken_i     = draw_bits(1) != 64'd0;
        exe_target_i    = ROM_BASE + (draw_bits(8) << 2);
    endtask

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk_i);
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("ERRORS FOUND");
                $finish;
            end
        end
    end

    initial begin
        lfsr         = 32'h1336b346;
        rstn_i       = 1'b0;
        reset_addr_i = ROM_BASE;
        drive_idle();
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        // plain sequential fetch first, then random traffic
        for (int c = 0; c < RUN_CYCLES; c++) begin
            if (c < WARMUP_CYCLES) begin
                drive_idle();
            end else begin
                drive_random();
            end
            @(negedge clk_i);
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
source/fetch_pkg.sv
source/pc_gen_stage.sv
source/branch_predictor.sv
source/fetch_unit.sv
dv/fetch_assert.sv
dv/fetch_checker.sv
dv/tb_fetch_unit.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch unit testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -sv -f files.f \
    --top-module tb_fetch_unit -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    exit 1
fi
exit 0

// ==== source/branch_predictor.sv ====
/*
 * Direct-mapped branch target buffer with 2-bit saturating counters.
 * Looked up combinationally with the fetch pc and trained by the
 * execute stage one cycle before the update becomes visible.
 */
`timescale 1ns/1ns
`default_nettype none

module branch_predictor #(
    parameter int unsigned BTB_ENTRIES = 16
) (
    input  logic                clk_i,
    input  logic                rstn_i,

    // lookup
    input  fetch_pkg::addr_pc_t fetch_pc_i,

    // training from execute
    input  logic                exe_is_branch_i,
    input  fetch_pkg::addr_pc_t exe_pc_i,
    input  logic                exe_taken_i,
    input  fetch_pkg::addr_pc_t exe_target_i,

    // prediction
    output logic                pred_hit_o,
    output logic                pred_taken_o,
    output fetch_pkg::addr_pc_t pred_target_o
);
    import fetch_pkg::*;

    localparam int unsigned IDX_W = $clog2(BTB_ENTRIES);
    localparam int unsigned TAG_W = 64 - 2 - IDX_W;

    typedef logic [IDX_W-1:0] btb_idx_t;
    typedef logic [TAG_W-1:0] btb_tag_t;
    typedef logic [1:0]       sat_cnt_t;

    // entry storage
    logic [BTB_ENTRIES-1:0] valid_q;
    btb_tag_t               tag_q    [BTB_ENTRIES];
    addr_pc_t               target_q [BTB_ENTRIES];
    sat_cnt_t               cnt_q    [BTB_ENTRIES];

    btb_idx_t fetch_idx;
    btb_tag_t fetch_tag;
    btb_idx_t exe_idx;
    btb_tag_t exe_tag;
    logic     exe_hit;
    sat_cnt_t cnt_next;
    logic     target_we;

    // one step toward the outcome, clamped at 0 and 3
    function automatic sat_cnt_t sat_step(input sat_cnt_t cnt, input logic taken);
        sat_cnt_t res;
        res = cnt;
        if (taken && cnt != 2'b11) begin
            res = cnt + 2'b01;
        end else if (!taken && cnt != 2'b00) begin
            res = cnt - 2'b01;
        end
        return res;
    endfunction

    // index sits just above the halfword bits
    assign fetch_idx = fetch_pc_i[IDX_W+1:2];
    assign fetch_tag = fetch_pc_i[63:IDX_W+2];
    assign exe_idx   = exe_pc_i[IDX_W+1:2];
    assign exe_tag   = exe_pc_i[63:IDX_W+2];

    // lookup
    assign pred_hit_o    = valid_q[fetch_idx] && (tag_q[fetch_idx] == fetch_tag);
    assign pred_taken_o  = cnt_q[fetch_idx][1];
    assign pred_target_o = target_q[fetch_idx];

    // training
    assign exe_hit = valid_q[exe_idx] && (tag_q[exe_idx] == exe_tag);

    always_comb begin
        if (exe_hit) begin
            cnt_next = sat_step(cnt_q[exe_idx], exe_taken_i);
        end else if (exe_taken_i) begin
            // new entry starts weakly taken
            cnt_next = 2'b10;
        end else begin
            // or weakly not taken
            cnt_next = 2'b01;
        end
    end

    // a hit keeps the old target unless this one was taken
    assign target_we = !exe_hit || exe_taken_i;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else if (exe_is_branch_i) begin
            valid_q[exe_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (exe_is_branch_i) begin
            tag_q[exe_idx] <= exe_tag;
            cnt_q[exe_idx] <= cnt_next;
            if (target_we) begin
                target_q[exe_idx] <= exe_target_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_pkg.sv ====
/*
 * Shared types and constants for the instruction fetch stage.
 * Address widths, the next-pc select encoding, exception causes and
 * the physical memory map used when translation is off.
 */
`default_nettype none

package fetch_pkg;

    // address widths
    localparam int unsigned VIRT_ADDR_SIZE = 39;
    localparam int unsigned VADDR_SIZE     = 40;

    typedef logic [63:0]           addr_pc_t;
    typedef logic [VADDR_SIZE-1:0] vaddr_t;
    typedef logic [63:0]           xcpt_cause_t;

    // next pc source, chosen by the control unit
    typedef enum logic [1:0] {
        NEXT_PC_KEEP      = 2'b00,
        NEXT_PC_BP_OR_PC4 = 2'b01,
        NEXT_PC_JUMP      = 2'b10,
        NEXT_PC_DEBUG     = 2'b11
    } next_pc_sel_e;

    // instruction exception causes
    localparam xcpt_cause_t CAUSE_INSTR_MISALIGNED   = 64'd0;
    localparam xcpt_cause_t CAUSE_INSTR_ACCESS_FAULT = 64'd1;

    // boot rom section
    localparam addr_pc_t ROM_BASE  = 64'h0000_0000_0000_0100;
    localparam addr_pc_t ROM_SIZE  = 64'h0000_0000_0001_0000;

    // main memory section
    localparam addr_pc_t DRAM_BASE = 64'h0000_0000_8000_0000;
    localparam addr_pc_t DRAM_SIZE = 64'h0000_0000_1000_0000;

    // true when addr falls inside one of the mapped sections
    function automatic logic in_mapped_section(input addr_pc_t addr);
        logic in_rom;
        logic in_dram;
        in_rom  = (addr >= ROM_BASE) && (addr < ROM_BASE + ROM_SIZE);
        in_dram = (addr >= DRAM_BASE) && (addr < DRAM_BASE + DRAM_SIZE);
        return in_rom || in_dram;
    endfunction

endpackage

`default_nettype wire

// ==== source/fetch_unit.sv ====
/*
 * Top level of the first fetch stage.
 * Ties the pc stage to the branch target buffer and exposes the icache
 * request, the fetch outputs and the execute training port.
 */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
    parameter int unsigned BTB_ENTRIES = 16
) (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  fetch_pkg::addr_pc_t     reset_addr_i,

    // control unit
    input  fetch_pkg::next_pc_sel_e next_pc_sel_i,
    input  fetch_pkg::addr_pc_t     jump_pc_i,
    input  logic                    stall_i,
    input  logic                    stall_debug_i,
    input  logic                    en_translation_i,
    input  logic                    invalidate_icache_i,
    input  logic                    invalidate_buffer_i,
    input  logic                    retry_fetch_i,

    // execute stage training
    input  logic                    exe_is_branch_i,
    input  fetch_pkg::addr_pc_t     exe_pc_i,
    input  logic                    exe_taken_i,
    input  fetch_pkg::addr_pc_t     exe_target_i,

    // icache request
    output logic                    icache_req_valid_o,
    output fetch_pkg::vaddr_t       icache_req_vaddr_o,
    output logic                    icache_inval_o,
    output logic                    icache_inval_buffer_o,
    output logic                    icache_inval_fetch_o,

    // to the second fetch stage
    output logic                    fetch_valid_o,
    output fetch_pkg::addr_pc_t     fetch_pc_o,
    output logic                    fetch_xcpt_valid_o,
    output fetch_pkg::xcpt_cause_t  fetch_xcpt_cause_o,
    output logic                    bpred_is_branch_o,
    output logic                    bpred_taken_o,
    output fetch_pkg::addr_pc_t     bpred_addr_o
);
    import fetch_pkg::*;

    addr_pc_t fetch_pc;
    logic     pred_hit;
    logic     pred_taken;
    addr_pc_t pred_target;

    assign fetch_pc_o = fetch_pc;

    pc_gen_stage pc_gen0 (
        .clk_i                 (clk_i),
        .rstn_i                (rstn_i),
        .reset_addr_i          (reset_addr_i),
        .next_pc_sel_i         (next_pc_sel_i),
        .jump_pc_i             (jump_pc_i),
        .stall_i               (stall_i),
        .stall_debug_i         (stall_debug_i),
        .en_translation_i      (en_translation_i),
        .invalidate_icache_i   (invalidate_icache_i),
        .invalidate_buffer_i   (invalidate_buffer_i),
        .retry_fetch_i         (retry_fetch_i),
        .pred_hit_i            (pred_hit),
        .pred_taken_i          (pred_taken),
        .pred_target_i         (pred_target),
        .icache_req_valid_o    (icache_req_valid_o),
        .icache_req_vaddr_o    (icache_req_vaddr_o),
        .icache_inval_o        (icache_inval_o),
        .icache_inval_buffer_o (icache_inval_buffer_o),
        .icache_inval_fetch_o  (icache_inval_fetch_o),
        .fetch_valid_o         (fetch_valid_o),
        .fetch_pc_o            (fetch_pc),
        .fetch_xcpt_valid_o    (fetch_xcpt_valid_o),
        .fetch_xcpt_cause_o    (fetch_xcpt_cause_o),
        .bpred_is_branch_o     (bpred_is_branch_o),
        .bpred_taken_o         (bpred_taken_o),
        .bpred_addr_o          (bpred_addr_o)
    );

    branch_predictor #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) bpred0 (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .fetch_pc_i      (fetch_pc),
        .exe_is_branch_i (exe_is_branch_i),
        .exe_pc_i        (exe_pc_i),
        .exe_taken_i     (exe_taken_i),
        .exe_target_i    (exe_target_i),
        .pred_hit_o      (pred_hit),
        .pred_taken_o    (pred_taken),
        .pred_target_o   (pred_target)
    );

endmodule

`default_nettype wire

// ==== source/pc_gen_stage.sv ====
/*
 * Program counter stage of instruction fetch.
 * Selects the next pc, checks the current pc for misalignment and access
 * faults, and drives the icache request together with the fetch outputs
 * and the branch prediction for later stages.
 */
`timescale 1ns/1ns
`default_nettype none

module pc_gen_stage (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  fetch_pkg::addr_pc_t    reset_addr_i,

    // control unit
    input  fetch_pkg::next_pc_sel_e next_pc_sel_i,
    input  fetch_pkg::addr_pc_t    jump_pc_i,
    input  logic                   stall_i,
    input  logic                   stall_debug_i,
    input  logic                   en_translation_i,
    input  logic                   invalidate_icache_i,
    input  logic                   invalidate_buffer_i,
    input  logic                   retry_fetch_i,

    // prediction for the current pc
    input  logic                   pred_hit_i,
    input  logic                   pred_taken_i,
    input  fetch_pkg::addr_pc_t    pred_target_i,

    // icache request
    output logic                   icache_req_valid_o,
    output fetch_pkg::vaddr_t      icache_req_vaddr_o,
    output logic                   icache_inval_o,
    output logic                   icache_inval_buffer_o,
    output logic                   icache_inval_fetch_o,

    // fetch outputs
    output logic                   fetch_valid_o,
    output fetch_pkg::addr_pc_t    fetch_pc_o,
    output logic                   fetch_xcpt_valid_o,
    output fetch_pkg::xcpt_cause_t fetch_xcpt_cause_o,
    output logic                   bpred_is_branch_o,
    output logic                   bpred_taken_o,
    output fetch_pkg::addr_pc_t    bpred_addr_o
);
    import fetch_pkg::*;

    addr_pc_t pc_q;
    addr_pc_t next_pc;

    logic     pred_redirect;
    logic     xcpt_misaligned;
    logic     xcpt_fault;
    logic     non_canonical;
    logic     stalled;

    // predicted taken only counts with a btb hit
    assign pred_redirect = pred_hit_i && pred_taken_i;

    always_comb begin
        priority case (next_pc_sel_i)
            NEXT_PC_KEEP: begin
                next_pc = pc_q;
            end
            NEXT_PC_BP_OR_PC4: begin
                if (pred_redirect) begin
                    next_pc = pred_target_i;
                end else begin
                    next_pc = pc_q + 64'd4;
                end
            end
            NEXT_PC_JUMP,
            NEXT_PC_DEBUG: begin
                next_pc = jump_pc_i;
            end
        endcase
    end

    // pc follows the select even during a stall
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= reset_addr_i;
        end else begin
            pc_q <= next_pc;
        end
    end

    // upper bits must all equal bit 38 for a valid sv39 address
    assign non_canonical = !((&pc_q[63:VIRT_ADDR_SIZE-1]) || !(|pc_q[63:VIRT_ADDR_SIZE-1]));

    always_comb begin
        if (en_translation_i) begin
            xcpt_fault = non_canonical;
        end else begin
            // physical mode, only the mapped sections are fetchable
            xcpt_fault = !in_mapped_section(pc_q);
        end
    end

    assign xcpt_misaligned = |pc_q[1:0];

    // misalignment wins over the access fault
    always_comb begin
        if (xcpt_misaligned) begin
            fetch_xcpt_valid_o = 1'b1;
            fetch_xcpt_cause_o = CAUSE_INSTR_MISALIGNED;
        end else if (xcpt_fault) begin
            fetch_xcpt_valid_o = 1'b1;
            fetch_xcpt_cause_o = CAUSE_INSTR_ACCESS_FAULT;
        end else begin
            fetch_xcpt_valid_o = 1'b0;
            fetch_xcpt_cause_o = '0;
        end
    end

    assign stalled = stall_i || stall_debug_i;

    // icache request
    assign icache_req_valid_o    = !xcpt_misaligned && !xcpt_fault && !stalled;
    assign icache_req_vaddr_o    = pc_q[VADDR_SIZE-1:0];
    assign icache_inval_o        = invalidate_icache_i;
    assign icache_inval_buffer_o = invalidate_buffer_i || retry_fetch_i;
    assign icache_inval_fetch_o  = retry_fetch_i;

    // fetch outputs
    assign fetch_valid_o = !stalled;
    assign fetch_pc_o    = pc_q;

    // prediction travels down the pipe with the instruction
    assign bpred_is_branch_o = pred_hit_i;
    assign bpred_taken_o     = pred_redirect;
    assign bpred_addr_o      = pred_target_i;

endmodule

`default_nettype wire
